//--- sim/i2c_cases.txt
# op (0 write, 1 read)  dev_addr  sub16  sub_addr  byte_count  expect_nack, all hex
# reads return what earlier writes stored, or the address fill pattern
0 50 0 0010 4 0
1 50 0 0010 4 0
0 50 1 1234 3 0
1 50 1 1234 3 0
1 50 1 0034 2 0
0 50 0 00fe 3 0
1 50 0 00fe 3 0
0 3c 0 0000 2 1
1 51 1 0100 1 1
0 50 0 0005 1 0
1 50 0 0005 1 0
1 50 0 0020 1 0
0 50 1 a5c3 6 0
1 50 1 a5c2 8 0
0 7f 1 0000 1 1
0 50 0 0040 2 0
1 50 0 0040 2 0

//--- build.f
+incdir+hw
hw/i2c_bus_pkg.sv
hw/i2c_host_pkg.sv
hw/i2c_scl_gen.sv
hw/i2c_line_sampler.sv
hw/i2c_byte_shifter.sv
hw/i2c_master_fsm.sv
hw/i2c_master.sv
sim/tb_i2c_master.sv

//--- Bender.yml
package:
  name: i2c_master

sources:
  - include_dirs:
      - hw
    files:
      - hw/i2c_bus_pkg.sv
      - hw/i2c_host_pkg.sv
      - hw/i2c_scl_gen.sv
      - hw/i2c_line_sampler.sv
      - hw/i2c_byte_shifter.sv
      - hw/i2c_master_fsm.sv
      - hw/i2c_master.sv
  - target: simulation
    files:
      - sim/tb_i2c_master.sv

//--- sim/tb_i2c_master.sv
`timescale 1ns/10ps

module tb_i2c_master;
    import i2c_bus_pkg::*;
    import i2c_host_pkg::*;

    logic      i_clk;
    logic      reset_n;
    host_req_t req;
    bus_byte_t wdata;
    host_rsp_t rsp;
    logic      scl_m;                       // master open-drain outputs
    logic      sda_m;
    logic      sda_s;                       // slave open-drain output
    wire       scl_bus = scl_m;             // wired-AND bus
    wire       sda_bus = sda_m & sda_s;

    logic [7:0]  mem [0:65535];             // slave register space
    logic [15:0] c_sub [0:31];
    logic [7:0]  c_dev [0:31];
    logic [7:0]  wbuf [0:255];              // generated write bytes of one case
    int          c_op [0:31];
    int          c_s16 [0:31];
    int          c_len [0:31];
    int          c_nack [0:31];
    int          n_cases;
    int          errors;
    int          cyc;
    int          cyc_limit;
    logic [31:0] rng;
    logic        slave_sub16;               // slave's view of the sub-address width

    // slave state and log
    logic        scl_q, sda_q, active, in_txn, rd_mode, rd_pend, rd_nack;
    logic [3:0]  bit_cnt;
    logic [7:0]  rx_sr, tx_sr;
    logic [15:0] ptr;
    int          byte_idx;
    int          start_cnt, restart_cnt, stop_cnt, addr_cnt, mack_cnt, mnack_cnt;

    i2c_master i2c_master_i (
        .i_clk   (i_clk),
        .reset_n (reset_n),
        .req_i   (req),
        .wdata_i (wdata),
        .rsp_o   (rsp),
        .scl_o   (scl_m),
        .sda_o   (sda_m),
        .sda_i   (sda_bus)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;          // 4 ns period
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc_limit != 0 && cyc > cyc_limit) begin
            $display("timeout: run did not finish within %0d cycles", cyc_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        end
    endtask

    // behavioural slave at 7'h50 working on bus levels seen at the falling i_clk edge
    always @(negedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_q   <= 1'b1;
            sda_q   <= 1'b1;
            sda_s   <= 1'b1;
            active  <= 1'b0;
            in_txn  <= 1'b0;
            rd_mode <= 1'b0;
            rd_pend <= 1'b0;
            rd_nack <= 1'b0;
            bit_cnt <= '0;
            ptr     <= '0;
        end else begin
            scl_q <= scl_bus;
            sda_q <= sda_bus;
            if (scl_bus && scl_q && sda_q && !sda_bus) begin    // start or repeated start
                if (in_txn) restart_cnt++;
                else start_cnt++;
                in_txn   <= 1'b1;
                active   <= 1'b1;
                bit_cnt  <= '0;
                byte_idx = 0;
                rd_mode  <= 1'b0;
                rd_pend  <= 1'b0;
                rd_nack  <= 1'b0;
                sda_s    <= 1'b1;
            end else if (scl_bus && scl_q && !sda_q && sda_bus) begin  // stop
                stop_cnt++;
                in_txn <= 1'b0;
                active <= 1'b0;
                sda_s  <= 1'b1;
            end else if (active && scl_bus && !scl_q) begin    // scl rise samples sda
                if (bit_cnt < 8) begin
                    if (!rd_mode) rx_sr <= {rx_sr[6:0], sda_bus};
                end else if (rd_mode) begin
                    if (sda_bus) begin
                        mnack_cnt++;
                        rd_nack <= 1'b1;
                    end else begin
                        mack_cnt++;
                    end
                end
                bit_cnt <= bit_cnt + 1'b1;
            end else if (active && !scl_bus && scl_q) begin    // scl fall drives sda
                if (bit_cnt == 8) begin
                    if (rd_mode) begin
                        sda_s <= 1'b1;                          // master owns the ack bit
                    end else if (byte_idx == 0) begin
                        addr_cnt++;
                        if (rx_sr[7:1] == 7'h50) begin
                            sda_s   <= 1'b0;
                            rd_pend <= rx_sr[0];
                        end else begin
                            active <= 1'b0;                    // other address keeps sda released
                            in_txn <= 1'b0;
                        end
                    end else begin
                        sda_s <= 1'b0;
                        if (byte_idx == 1 && slave_sub16) ptr <= {rx_sr, 8'h00};
                        else if (byte_idx == 1) ptr <= {8'h00, rx_sr};
                        else if (byte_idx == 2 && slave_sub16) ptr[7:0] <= rx_sr;
                        else begin
                            mem[ptr] <= rx_sr;
                            ptr      <= ptr + 1'b1;            // auto-increment
                        end
                    end
                    byte_idx++;
                end else if (bit_cnt == 9) begin
                    bit_cnt <= '0;
                    sda_s   <= 1'b1;
                    if ((rd_mode || rd_pend) && !rd_nack) begin
                        rd_mode <= 1'b1;
                        tx_sr   <= mem[ptr];
                        sda_s   <= mem[ptr][7];
                        ptr     <= ptr + 1'b1;
                    end
                end else if (rd_mode && !rd_nack) begin
                    sda_s <= tx_sr[3'd7 - bit_cnt[2:0]];
                end
            end
        end
    end

    task automatic run_case(input int k);
        int s0, r0, p0, a0, ma0, mn0, nw, nr, widx, exp_ok;
        logic [15:0] base;
        exp_ok = !c_nack[k];
        base = c_s16[k] ? c_sub[k] : {8'h00, c_sub[k][7:0]};
        for (int i = 0; i < c_len[k]; i++) begin
            rng = xorshift(rng);
            wbuf[i] = rng[7:0];
        end
        s0 = start_cnt;
        r0 = restart_cnt;
        p0 = stop_cnt;
        a0 = addr_cnt;
        ma0 = mack_cnt;
        mn0 = mnack_cnt;
        nw = 0;
        nr = 0;
        widx = 0;
        slave_sub16 = c_s16[k][0];
        req.dev_addr = c_dev[k][6:0];
        req.rw       = c_op[k][0];
        req.sub_len  = c_s16[k][0];
        req.sub_addr = c_sub[k];
        req.byte_len = byte_len_t'(c_len[k]);
        req.start    = 1'b1;                    // stays high through busy and must start nothing
        wdata        = wbuf[0];
        @(negedge i_clk);
        check("busy", 1, rsp.status.busy);
        while (rsp.status.busy) begin
            if (rsp.wreq) begin
                nw++;
                widx++;
                wdata = wbuf[widx];             // valid on the cycle after wreq
            end
            if (rsp.rvalid) begin
                check("rdata", mem[base + nr], rsp.rdata);
                nr++;
            end
            @(negedge i_clk);
        end
        req.start = 1'b0;
        check("nack", c_nack[k], rsp.status.nack);
        check("wreq pulses", (exp_ok && c_op[k] == 0) ? c_len[k] - 1 : 0, nw);
        check("rvalid pulses", (exp_ok && c_op[k] == 1) ? c_len[k] : 0, nr);
        check("slave starts", 1, start_cnt - s0);
        check("slave restarts", (exp_ok && c_op[k] == 1) ? 1 : 0, restart_cnt - r0);
        check("slave stops", exp_ok, stop_cnt - p0);
        check("slave addr bytes", (exp_ok && c_op[k] == 1) ? 2 : 1, addr_cnt - a0);
        if (exp_ok && c_op[k] == 1) begin
            check("master acks", c_len[k] - 1, mack_cnt - ma0);
            check("master nacks", 1, mnack_cnt - mn0);
        end
        if (exp_ok && c_op[k] == 0) begin
            for (int i = 0; i < c_len[k]; i++) check("slave mem", wbuf[i], mem[base + i]);
        end
        repeat (60) @(negedge i_clk);           // bus free time
    endtask

    initial begin
        int fd, total;
        string line;
        int a, b, c, d, e, f;
        reset_n = 1'b0;
        req = '0;
        wdata = '0;
        sda_s = 1'b1;
        errors = 0;
        cyc = 0;
        cyc_limit = 0;
        n_cases = 0;
        total = 0;
        rng = 32'hd5ef;
        slave_sub16 = 1'b0;
        start_cnt = 0;
        restart_cnt = 0;
        stop_cnt = 0;
        addr_cnt = 0;
        mack_cnt = 0;
        mnack_cnt = 0;
        byte_idx = 0;
        for (int i = 0; i < 65536; i++) mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;
        fd = $fopen("sim/i2c_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file sim/i2c_cases.txt");
            $display("Test FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != 8'h23) begin
                    if ($sscanf(line, "%h %h %h %h %h %h", a, b, c, d, e, f) == 6) begin
                        c_op[n_cases] = a;
                        c_dev[n_cases] = b;
                        c_s16[n_cases] = c;
                        c_sub[n_cases] = d;
                        c_len[n_cases] = e;
                        c_nack[n_cases] = f;
                        total += (e + 4) * 9 * 250;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
            cyc_limit = total + 2000 * n_cases + 10000;
            repeat (3) @(negedge i_clk);
            reset_n = 1'b1;
            @(negedge i_clk);
            check("busy", 0, rsp.status.busy);
            check("nack", 0, rsp.status.nack);
            check("rvalid", 0, rsp.rvalid);
            check("wreq", 0, rsp.wreq);
            check("scl", 1, scl_bus);
            check("sda", 1, sda_bus);
            if (n_cases == 0) begin
                errors++;
                $display("the case file holds no cases");
            end
            for (int k = 0; k < n_cases; k++) run_case(k);
            $display("%0d errors in %0d cases", errors, n_cases);
            if (errors == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

//--- hw/i2c_master.sv
`timescale 1ns/10ps

module i2c_master (
    input  logic                    i_clk,
    input  logic                    reset_n,
    input  i2c_host_pkg::host_req_t req_i,
    input  i2c_bus_pkg::bus_byte_t  wdata_i,
    output i2c_host_pkg::host_rsp_t rsp_o,
    output logic                    scl_o,        // open drain, 1 releases
    output logic                    sda_o,        // open drain, 1 releases
    input  logic                    sda_i         // wired sda level
);
    import i2c_bus_pkg::*;

    logic       scl_en;
    logic       scl_lvl;
    phase_cnt_t phase;
    logic       scl_rise;
    logic       scl_fall;
    logic       sda_sync;
    logic       sh_load;
    bus_byte_t  sh_byte;
    logic       sh_out;
    logic       sh_in;
    logic       sh_clear;
    logic       sh_msb;
    bus_byte_t  sh_rx;
    logic       sh_done;

    i2c_scl_gen scl_gen_i (
        .i_clk   (i_clk),
        .reset_n (reset_n),
        .en_i    (scl_en),
        .scl_o   (scl_lvl),
        .phase_o (phase)
    );

    i2c_line_sampler line_sampler_i (
        .i_clk      (i_clk),
        .reset_n    (reset_n),
        .sda_i      (sda_i),
        .scl_i      (scl_lvl),
        .sda_sync_o (sda_sync),
        .scl_rise_o (scl_rise),
        .scl_fall_o (scl_fall)
    );

    i2c_byte_shifter byte_shifter_i (
        .i_clk       (i_clk),
        .reset_n     (reset_n),
        .load_i      (sh_load),
        .load_byte_i (sh_byte),
        .shift_out_i (sh_out),
        .shift_in_i  (sh_in),
        .in_bit_i    (sda_sync),
        .msb_o       (sh_msb),
        .rx_byte_o   (sh_rx),
        .done_o      (sh_done),
        .clear_i     (sh_clear)
    );

    i2c_master_fsm master_fsm_i (
        .i_clk      (i_clk),
        .reset_n    (reset_n),
        .req_i      (req_i),
        .wdata_i    (wdata_i),
        .rsp_o      (rsp_o),
        .scl_en_o   (scl_en),
        .sda_o      (sda_o),
        .phase_i    (phase),
        .scl_rise_i (scl_rise),
        .scl_fall_i (scl_fall),
        .sda_sync_i (sda_sync),
        .sh_load_o  (sh_load),
        .sh_byte_o  (sh_byte),
        .sh_out_o   (sh_out),
        .sh_in_o    (sh_in),
        .sh_clear_o (sh_clear),
        .msb_i      (sh_msb),
        .rx_byte_i  (sh_rx),
        .done_i     (sh_done)
    );

    assign scl_o = ~scl_en | scl_lvl;   // pulled low only by a running generator

endmodule

//--- hw/i2c_master_fsm.sv
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_master_fsm (
    input  logic                    i_clk,
    input  logic                    reset_n,
    input  i2c_host_pkg::host_req_t req_i,
    input  i2c_bus_pkg::bus_byte_t  wdata_i,      // write byte from the host
    output i2c_host_pkg::host_rsp_t rsp_o,
    output logic                    scl_en_o,     // runs the scl generator
    output logic                    sda_o,        // open drain, 1 releases the line
    input  i2c_bus_pkg::phase_cnt_t phase_i,
    input  logic                    scl_rise_i,
    input  logic                    scl_fall_i,
    input  logic                    sda_sync_i,
    output logic                    sh_load_o,
    output i2c_bus_pkg::bus_byte_t  sh_byte_o,
    output logic                    sh_out_o,
    output logic                    sh_in_o,
    output logic                    sh_clear_o,
    input  logic                    msb_i,
    input  i2c_bus_pkg::bus_byte_t  rx_byte_i,
    input  logic                    done_i
);
    import i2c_bus_pkg::*;
    import i2c_host_pkg::*;

    localparam phase_cnt_t SAMPLE_PH  = phase_cnt_t'(`I2C_SAMPLE_OFS);
    localparam phase_cnt_t HOLD_PH    = phase_cnt_t'(`I2C_DATA_HOLD);
    localparam phase_cnt_t STOP_PH    = phase_cnt_t'(`I2C_STOP_SETUP);
    localparam phase_cnt_t RELEASE_PH = phase_cnt_t'(`I2C_RELEASE_OFS);

    master_state_e state;
    master_state_e next_st;          // target after an ack bit
    host_req_t     req_q;            // captured request
    bus_byte_t     wbyte_q;          // first write byte
    byte_len_t     byte_cnt;         // data bytes finished
    logic          armed;            // scl edge seen, waiting for the phase offset
    logic          step;             // ack driven in ACK_TX, sda already low in STOP
    logic          sub_done;         // sub-address sent, next address byte is a read
    logic          sub_hi;           // low sub-address byte still pending
    logic          accept;
    logic          last_byte;
    logic          hold_hit;         // sda change point in scl low
    logic          sample_hit;       // sample point in scl high

    assign accept     = (state == IDLE) && req_i.start && !rsp_o.status.busy;
    assign last_byte  = (byte_cnt == req_q.byte_len - 1'b1);
    assign hold_hit   = armed && (phase_i == HOLD_PH);
    assign sample_hit = armed && (phase_i == SAMPLE_PH);

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_q   <= req_i;
            wbyte_q <= wdata_i;
        end
    end

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= IDLE;
            next_st    <= IDLE;
            rsp_o      <= '0;
            scl_en_o   <= 1'b0;
            sda_o      <= 1'b1;
            sh_load_o  <= 1'b0;
            sh_byte_o  <= '0;
            sh_out_o   <= 1'b0;
            sh_in_o    <= 1'b0;
            sh_clear_o <= 1'b0;
            byte_cnt   <= '0;
            armed      <= 1'b0;
            step       <= 1'b0;
            sub_done   <= 1'b0;
            sub_hi     <= 1'b0;
        end else begin
            rsp_o.rvalid <= 1'b0;                    // one-cycle strobes
            rsp_o.wreq   <= 1'b0;
            sh_load_o    <= 1'b0;
            sh_out_o     <= 1'b0;
            sh_in_o      <= 1'b0;
            sh_clear_o   <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        rsp_o.status.busy <= 1'b1;
                        rsp_o.status.nack <= 1'b0;
                        scl_en_o <= 1'b1;
                        sub_hi   <= req_i.sub_len;
                        sub_done <= 1'b0;
                        byte_cnt <= '0;
                        state    <= START;
                    end
                end
                START: begin
                    if (phase_i == SAMPLE_PH) begin  // still the first scl high phase
                        sda_o     <= 1'b0;
                        sh_load_o <= 1'b1;
                        sh_byte_o <= {req_q.dev_addr, 1'b0};  // reads turn around at restart
                        armed     <= 1'b0;
                        state     <= SLAVE_ADDR;
                    end
                end
                RESTART: begin
                    if (scl_fall_i) sda_o <= 1'b1;   // let sda up while scl is low
                    if (scl_rise_i) armed <= 1'b1;
                    if (sample_hit) begin
                        armed     <= 1'b0;
                        sda_o     <= 1'b0;           // repeated start
                        sh_load_o <= 1'b1;
                        sh_byte_o <= {req_q.dev_addr, 1'b1};
                        state     <= SLAVE_ADDR;
                    end
                end
                SLAVE_ADDR, SUB_ADDR, WRITE: begin
                    if (scl_fall_i) armed <= 1'b1;
                    if (hold_hit && !done_i) begin
                        armed    <= 1'b0;
                        sda_o    <= msb_i;
                        sh_out_o <= 1'b1;
                    end else if (hold_hit) begin     // ninth clock belongs to the slave
                        armed <= 1'b0;
                        sda_o <= 1'b1;
                        state <= ACK_RX;
                        case (state)
                            SLAVE_ADDR: begin
                                next_st   <= sub_done ? READ : SUB_ADDR;
                                sh_load_o <= 1'b1;   // also clears done for a read
                                sh_byte_o <= sub_hi ? req_q.sub_addr[15:8] : req_q.sub_addr[7:0];
                            end
                            SUB_ADDR: begin
                                sh_load_o <= 1'b1;
                                if (sub_hi) begin
                                    sub_hi    <= 1'b0;
                                    sh_byte_o <= req_q.sub_addr[7:0];
                                    next_st   <= SUB_ADDR;
                                end else begin
                                    sub_done  <= 1'b1;
                                    sh_byte_o <= wbyte_q;
                                    next_st   <= req_q.rw ? RESTART : WRITE;
                                end
                            end
                            default: begin
                                byte_cnt <= byte_cnt + 1'b1;
                                next_st  <= last_byte ? STOP : GRAB_DATA;
                            end
                        endcase
                    end
                end
                GRAB_DATA: begin
                    if (!armed) begin
                        rsp_o.wreq <= 1'b1;
                        armed      <= 1'b1;
                    end else if (!rsp_o.wreq) begin  // host byte valid the cycle after wreq
                        armed     <= 1'b0;
                        sh_load_o <= 1'b1;
                        sh_byte_o <= wdata_i;
                        state     <= WRITE;
                    end
                end
                ACK_RX: begin
                    if (scl_rise_i) armed <= 1'b1;
                    if (sample_hit) begin
                        armed <= 1'b0;
                        if (!sda_sync_i) begin
                            state <= next_st;        // low is an ack
                        end else begin
                            rsp_o.status.busy <= 1'b0;
                            rsp_o.status.nack <= 1'b1;
                            scl_en_o <= 1'b0;
                            state    <= IDLE;
                        end
                    end
                end
                READ: begin
                    if (scl_rise_i) armed <= 1'b1;
                    if (done_i) begin
                        rsp_o.rdata  <= rx_byte_i;
                        rsp_o.rvalid <= 1'b1;
                        sh_clear_o   <= 1'b1;
                        byte_cnt     <= byte_cnt + 1'b1;
                        next_st      <= last_byte ? STOP : READ;
                        state        <= ACK_TX;
                    end else if (sample_hit) begin
                        armed   <= 1'b0;
                        sh_in_o <= 1'b1;
                    end
                end
                ACK_TX: begin
                    if (scl_fall_i) armed <= 1'b1;
                    if (hold_hit) begin
                        armed <= 1'b0;
                        if (!step) begin
                            sda_o <= (next_st == STOP);  // nack after the last byte
                            step  <= 1'b1;
                        end else if (next_st == STOP) begin
                            sda_o <= 1'b0;           // step stays set for STOP
                            state <= STOP;
                        end else begin
                            sda_o <= 1'b1;
                            step  <= 1'b0;
                            state <= READ;
                        end
                    end
                end
                STOP: begin
                    if (!step && scl_fall_i) begin   // write path, slave ack still low
                        sda_o <= 1'b0;
                        step  <= 1'b1;
                    end
                    if (step && scl_rise_i) armed <= 1'b1;
                    if (armed && phase_i == STOP_PH) begin
                        armed <= 1'b0;
                        step  <= 1'b0;
                        sda_o <= 1'b1;               // stop condition
                        state <= RELEASE_BUS;
                    end
                end
                RELEASE_BUS: begin
                    if (phase_i == RELEASE_PH) begin
                        scl_en_o <= 1'b0;
                        rsp_o.status.busy <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- hw/i2c_byte_shifter.sv
`timescale 1ns/10ps

module i2c_byte_shifter (
    input  logic                   i_clk,
    input  logic                   reset_n,
    input  logic                   load_i,        // take load_byte_i, restart the count
    input  i2c_bus_pkg::bus_byte_t load_byte_i,
    input  logic                   shift_out_i,   // next tx bit
    input  logic                   shift_in_i,    // capture in_bit_i
    input  logic                   in_bit_i,
    output logic                   msb_o,         // bit to put on sda
    output i2c_bus_pkg::bus_byte_t rx_byte_o,
    output logic                   done_o,        // eight shifts seen
    input  logic                   clear_i
);
    import i2c_bus_pkg::*;

    localparam bit_idx_t LAST_BIT = bit_idx_t'(7);

    bus_byte_t tx_sr;
    bit_idx_t  bit_cnt;

    // shift counter and done flag
    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt <= '0;
            done_o  <= 1'b0;
        end else if (load_i || clear_i) begin
            bit_cnt <= '0;
            done_o  <= 1'b0;
        end else if (shift_out_i || shift_in_i) begin
            bit_cnt <= bit_cnt + 1'b1;               // wraps back to zero after the byte
            if (bit_cnt == LAST_BIT) begin
                done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_i) begin
            tx_sr <= load_byte_i;
        end else if (shift_out_i) begin
            tx_sr <= {tx_sr[6:0], 1'b0};              // msb first
        end
        if (shift_in_i) begin
            rx_byte_o <= {rx_byte_o[6:0], in_bit_i};  // first bit ends up in bit 7
        end
    end

    assign msb_o = tx_sr[7];

endmodule

//--- hw/i2c_line_sampler.sv
`timescale 1ns/10ps

module i2c_line_sampler (
    input  logic i_clk,
    input  logic reset_n,
    input  logic sda_i,                  // raw sda pin, driven by the slave too
    input  logic scl_i,                  // scl level from the generator
    output logic sda_sync_o,             // sda after the two-stage synchronizer
    output logic scl_rise_o,
    output logic scl_fall_o
);

    logic [1:0] sda_ff;                  // synchronizer chain
    logic       scl_cur;
    logic       scl_prev;

    // sampled on the falling edge so the fsm sees settled values half a cycle later
    always_ff @(negedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            sda_ff   <= 2'b11;           // idle bus reads high
            scl_cur  <= 1'b1;
            scl_prev <= 1'b1;
        end else begin
            sda_ff   <= {sda_ff[0], sda_i};
            scl_cur  <= scl_i;
            scl_prev <= scl_cur;
        end
    end

    assign sda_sync_o = sda_ff[1];
    assign scl_rise_o = scl_cur & ~scl_prev;
    assign scl_fall_o = ~scl_cur & scl_prev;

endmodule

//--- hw/i2c_scl_gen.sv
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_scl_gen (
    input  logic                    i_clk,
    input  logic                    reset_n,
    input  logic                    en_i,         // run the divider
    output logic                    scl_o,        // scl level, high while stopped
    output i2c_bus_pkg::phase_cnt_t phase_o       // position inside the half period
);
    import i2c_bus_pkg::*;

    localparam phase_cnt_t LAST_PH = phase_cnt_t'(`I2C_SCL_DIV - 1);

    always_ff @(posedge i_clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_o   <= 1'b1;
            phase_o <= '0;
        end else if (!en_i) begin
            scl_o   <= 1'b1;                         // first half period after enable is high
            phase_o <= '0;
        end else if (phase_o == LAST_PH) begin
            scl_o   <= ~scl_o;                       // toggle every half period
            phase_o <= '0;
        end else begin
            phase_o <= phase_o + 1'b1;
        end
    end

endmodule

//--- hw/i2c_host_pkg.sv
package i2c_host_pkg;

    typedef logic [15:0] sub_addr_t;          // register address inside the slave
    typedef logic [23:0] byte_len_t;          // number of data bytes per transaction

    // one transaction request, taken when start is high and busy is low
    typedef struct packed {
        logic       start;                    // request strobe
        logic [6:0] dev_addr;                 // 7-bit slave address
        logic       rw;                       // 1 reads, 0 writes
        logic       sub_len;                  // 1 for a 16-bit sub-address
        sub_addr_t  sub_addr;
        byte_len_t  byte_len;
    } host_req_t;

    typedef struct packed {
        logic busy;                           // transaction in flight
        logic nack;                           // last transaction refused by the slave
    } host_status_t;

    // everything the master returns to the host
    typedef struct packed {
        logic [7:0]   rdata;                  // read byte
        logic         rvalid;                 // rdata strobe, no back-pressure
        logic         wreq;                   // next write byte wanted
        host_status_t status;
    } host_rsp_t;

endpackage

//--- hw/i2c_bus_pkg.sv
package i2c_bus_pkg;

    typedef logic [15:0] phase_cnt_t;         // i_clk count inside one scl half period
    typedef logic [2:0]  bit_idx_t;           // bit position inside a byte
    typedef logic [7:0]  bus_byte_t;          // one byte on sda

    // transaction sequencer states
    typedef enum logic [3:0] {
        IDLE        = 4'd0,                   // waiting for a host request
        START       = 4'd1,                   // sda falls while scl is high
        RESTART     = 4'd2,                   // repeated start before the read address
        SLAVE_ADDR  = 4'd3,                   // 7-bit address plus r/w bit
        SUB_ADDR    = 4'd4,                   // register address, high byte first
        READ        = 4'd5,                   // collect one byte from the slave
        WRITE       = 4'd6,                   // send one data byte
        GRAB_DATA   = 4'd7,                   // fetch the next write byte from host
        ACK_RX      = 4'd8,                   // sample the slave ack
        ACK_TX      = 4'd9,                   // drive ack or nack after a read byte
        STOP        = 4'd10,                  // sda rises while scl is high
        RELEASE_BUS = 4'd11                   // scl off, bus idle again
    } master_state_e;

endpackage

//--- hw/i2c_cfg.svh
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// scl timing for a 100 MHz i_clk and a 400 kHz bus clock
// all offsets are counts of the phase counter within one scl half period

`define I2C_SCL_DIV     125                   // i_clk cycles per scl half period
`define I2C_SAMPLE_OFS  70                    // sda sample and start point in scl high
`define I2C_DATA_HOLD   3                     // sda change point after scl falls
`define I2C_STOP_SETUP  60                    // sda rise point in scl high for a stop
`define I2C_RELEASE_OFS (`I2C_SCL_DIV - 3)    // bus release just before the phase wraps

`endif
